// File: hw/memspeed_macros.svh
// memory speedometer widths and timing.
// shared by the sequencer, the memory model, the monitor and the top level.

`ifndef MEMSPEED_MACROS_SVH
`define MEMSPEED_MACROS_SVH

// access counter and run length.
`define MEMSPEED_COUNT_W 16

// 1024 words.
`define MEMSPEED_ADDR_W 10

// two copies of the access count.
`define MEMSPEED_DATA_W 32

// cycles from accepted access to ack.
`define MEMSPEED_WR_LAT 3
`define MEMSPEED_RD_LAT 5

// refresh starts every period, counted from reset.
`define MEMSPEED_REF_PERIOD 64

// cycles a refresh keeps new accesses out.
`define MEMSPEED_REF_CYCLES 6

`endif

// File: hw/memspeed_pkg.sv
// memory speedometer types.
// sequencer state and the status shown on the display.

`default_nettype none

package memspeed_pkg;

  // sequencer state, also watched by the monitor.
  typedef enum logic [1:0] {
    SEQ_IDLE     = 2'd0,
    SEQ_REQUEST  = 2'd1,
    SEQ_ADVANCE  = 2'd2,
    SEQ_FINISHED = 2'd3
  } seq_state_e;

  // what the seven-segment display reports.
  typedef struct packed {
    seq_state_e run_state;
    logic       busy;
    logic       error;
  } status_t;

endpackage

`default_nettype wire

// File: hw/mem_bus_if.sv
// request/ack memory bus.
// stb is a level held until the one-cycle ack that ends the access.

`default_nettype none

`include "memspeed_macros.svh"

interface mem_bus_if;

  logic                        stb;
  logic                        we;
  logic [`MEMSPEED_ADDR_W-1:0] addr;
  logic [`MEMSPEED_DATA_W-1:0] wdata;
  logic [`MEMSPEED_DATA_W-1:0] rdata;
  // rdata is valid only with ack on a read.
  logic                        ack;

  modport requester (output stb, we, addr, wdata, input rdata, ack);

  modport memory (input stb, we, addr, wdata, output rdata, ack);

  modport monitor (input stb, we, addr, wdata, rdata, ack);

endinterface

`default_nettype wire

// File: hw/seq_decode.sv
// access sequencer.
// steps the access count and decodes it into bus requests.

`default_nettype none

`include "memspeed_macros.svh"

module seq_decode (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          start,
  input  wire [`MEMSPEED_COUNT_W-1:0]  run_len,
  mem_bus_if.requester                 bus,
  output memspeed_pkg::seq_state_e     state
);

  logic [`MEMSPEED_COUNT_W-1:0] count;
  logic [`MEMSPEED_COUNT_W-1:0] count_inc;
  logic [`MEMSPEED_COUNT_W-1:0] len_q;
  logic [`MEMSPEED_COUNT_W-1:0] wr_count;
  logic                         start_ok;
  memspeed_pkg::seq_state_e     state_next;

  // a new run may only begin when the previous one is over.
  assign start_ok = start &&
                    (state == memspeed_pkg::SEQ_IDLE || state == memspeed_pkg::SEQ_FINISHED);

  assign count_inc = count + 1'b1;

  always_comb begin
    state_next = state;
    case (state)
      memspeed_pkg::SEQ_IDLE,
      memspeed_pkg::SEQ_FINISHED: begin
        if (start_ok) begin
          if (run_len == '0) begin
            state_next = memspeed_pkg::SEQ_FINISHED;
          end else begin
            state_next = memspeed_pkg::SEQ_REQUEST;
          end
        end
      end
      memspeed_pkg::SEQ_REQUEST: begin
        if (bus.ack) begin
          state_next = memspeed_pkg::SEQ_ADVANCE;
        end
      end
      memspeed_pkg::SEQ_ADVANCE: begin
        // count still holds the access just finished.
        if (count_inc == len_q) begin
          state_next = memspeed_pkg::SEQ_FINISHED;
        end else begin
          state_next = memspeed_pkg::SEQ_REQUEST;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= memspeed_pkg::SEQ_IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      if (start_ok) begin
        count <= '0;
      end else if (state == memspeed_pkg::SEQ_ADVANCE) begin
        count <= count_inc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_ok) begin
      len_q <= run_len;
    end
  end

  // groups of four accesses share one address.
  // first one writes, the other three read back.
  assign wr_count = {count[`MEMSPEED_COUNT_W-1:2], 2'b00};

  assign bus.stb   = (state == memspeed_pkg::SEQ_REQUEST);
  assign bus.we    = (count[1:0] == 2'b00);
  assign bus.addr  = count[`MEMSPEED_ADDR_W+1:2];
  assign bus.wdata = {wr_count, wr_count};

endmodule

`default_nettype wire

// File: hw/mem_execute.sv
// memory model behind the request/ack bus.
// fixed read and write latency, plus periodic refresh that holds off new accesses.

`default_nettype none

`include "memspeed_macros.svh"

module mem_execute (
  input  wire        clk,
  input  wire        rst,
  mem_bus_if.memory  bus
);

  localparam int unsigned DEPTH   = 1 << `MEMSPEED_ADDR_W;
  localparam int unsigned LAT_W   = $clog2(`MEMSPEED_RD_LAT + 1);
  localparam int unsigned TIMER_W = $clog2(`MEMSPEED_REF_PERIOD);
  localparam int unsigned LEFT_W  = $clog2(`MEMSPEED_REF_CYCLES);

  // countdown start values, ack fires when the count reaches zero.
  localparam logic [LAT_W-1:0]   WR_LOAD  = LAT_W'(`MEMSPEED_WR_LAT - 1);
  localparam logic [LAT_W-1:0]   RD_LOAD  = LAT_W'(`MEMSPEED_RD_LAT - 1);
  localparam logic [TIMER_W-1:0] REF_LAST = TIMER_W'(`MEMSPEED_REF_PERIOD - 1);
  localparam logic [LEFT_W-1:0]  REF_LOAD = LEFT_W'(`MEMSPEED_REF_CYCLES - 1);

  logic [`MEMSPEED_DATA_W-1:0] mem [DEPTH];
  logic [`MEMSPEED_DATA_W-1:0] rdata_q;

  logic                        in_flight;
  logic [LAT_W-1:0]            lat_cnt;
  logic                        accept;

  logic [TIMER_W-1:0]          ref_timer;
  logic                        ref_req;
  logic [LEFT_W-1:0]           ref_left;
  logic                        ref_go;
  logic                        refreshing;

  // a due refresh waits for the running access to ack.
  assign ref_go     = ref_req && !in_flight && (ref_left == '0);
  assign refreshing = ref_req || (ref_left != '0);

  assign accept = bus.stb && !in_flight && !refreshing;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= 1'b0;
      lat_cnt   <= '0;
    end else if (accept) begin
      in_flight <= 1'b1;
      lat_cnt   <= bus.we ? WR_LOAD : RD_LOAD;
    end else if (in_flight) begin
      if (lat_cnt == '0) begin
        in_flight <= 1'b0;
      end else begin
        lat_cnt <= lat_cnt - 1'b1;
      end
    end
  end

  // writes land at acceptance.
  // only one access runs at a time, so a read can fetch its word at acceptance too.
  always_ff @(posedge clk) begin
    if (accept && bus.we) begin
      mem[bus.addr] <= bus.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !bus.we) begin
      rdata_q <= mem[bus.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ref_timer <= '0;
      ref_req   <= 1'b0;
      ref_left  <= '0;
    end else begin
      if (ref_timer == REF_LAST) begin
        ref_timer <= '0;
      end else begin
        ref_timer <= ref_timer + 1'b1;
      end

      if (ref_timer == REF_LAST) begin
        ref_req <= 1'b1;
      end else if (ref_go) begin
        ref_req <= 1'b0;
      end

      // the start cycle plus the countdown make one refresh window.
      if (ref_go) begin
        ref_left <= REF_LOAD;
      end else if (ref_left != '0) begin
        ref_left <= ref_left - 1'b1;
      end
    end
  end

  assign bus.ack   = in_flight && (lat_cnt == '0);
  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/result_monitor.sv
// run monitor for the memory speedometer.
// counts cycles and accesses, checks reads, builds a signature, drives the display.

`default_nettype none

`include "memspeed_macros.svh"

module result_monitor (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            start,
  input  wire memspeed_pkg::seq_state_e  state,
  mem_bus_if.monitor                     bus,
  output logic                           busy,
  output logic                           done,
  output logic [`MEMSPEED_COUNT_W-1:0]   access_count,
  output logic [`MEMSPEED_COUNT_W-1:0]   error_count,
  output logic [31:0]                    cycle_count,
  output logic [`MEMSPEED_DATA_W-1:0]    signature,
  output logic [6:0]                     ssl
);

  // segment patterns, bit order gfedcba.
  localparam logic [6:0] SEG_DASH = 7'b1000000;
  localparam logic [6:0] SEG_R    = 7'b1010000;
  localparam logic [6:0] SEG_A    = 7'b1110111;
  localparam logic [6:0] SEG_B    = 7'b1111100;
  localparam logic [6:0] SEG_D    = 7'b1011110;
  localparam logic [6:0] SEG_E    = 7'b1111001;

  logic                        start_ok;
  logic                        wr_ack;
  logic                        rd_ack;
  logic [`MEMSPEED_DATA_W-1:0] expect_q;
  memspeed_pkg::status_t       status;

  // same acceptance rule as the sequencer.
  assign start_ok = start &&
                    (state == memspeed_pkg::SEQ_IDLE || state == memspeed_pkg::SEQ_FINISHED);

  assign wr_ack = bus.ack && bus.we;
  assign rd_ack = bus.ack && !bus.we;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy         <= 1'b0;
      done         <= 1'b0;
      access_count <= '0;
      error_count  <= '0;
      cycle_count  <= '0;
      signature    <= '0;
    end else if (start_ok) begin
      busy         <= 1'b1;
      done         <= 1'b0;
      access_count <= '0;
      error_count  <= '0;
      cycle_count  <= '0;
      signature    <= '0;
    end else begin
      if (busy && state == memspeed_pkg::SEQ_FINISHED) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
      if (busy) begin
        cycle_count <= cycle_count + 1'b1;
      end
      if (bus.ack) begin
        access_count <= access_count + 1'b1;
      end
      if (rd_ack) begin
        signature <= signature ^ bus.rdata;
        if (bus.rdata != expect_q) begin
          error_count <= error_count + 1'b1;
        end
      end
    end
  end

  // reads of a group are checked against the group's write.
  always_ff @(posedge clk) begin
    if (wr_ack) begin
      expect_q <= bus.wdata;
    end
  end

  assign status = '{run_state: state, busy: busy, error: (error_count != '0)};

  always_comb begin
    if (status.error) begin
      ssl = SEG_E;
    end else if (status.busy) begin
      case (status.run_state)
        memspeed_pkg::SEQ_REQUEST: ssl = SEG_R;
        memspeed_pkg::SEQ_ADVANCE: ssl = SEG_A;
        default:                   ssl = SEG_B;
      endcase
    end else if (status.run_state == memspeed_pkg::SEQ_FINISHED) begin
      ssl = SEG_D;
    end else begin
      ssl = SEG_DASH;
    end
  end

endmodule

`default_nettype wire

// File: hw/memspeed.sv
// memory speedometer top level.
// sequencer, memory model and monitor share one request/ack bus.

`default_nettype none

`include "memspeed_macros.svh"

module memspeed (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           start,
  input  wire [`MEMSPEED_COUNT_W-1:0]   run_len,
  output logic                          busy,
  output logic                          done,
  output logic [`MEMSPEED_COUNT_W-1:0]  access_count,
  output logic [`MEMSPEED_COUNT_W-1:0]  error_count,
  output logic [31:0]                   cycle_count,
  output logic [`MEMSPEED_DATA_W-1:0]   signature,
  output logic [6:0]                    ssl
);

  memspeed_pkg::seq_state_e seq_state;

  mem_bus_if i_bus ();

  seq_decode i_decode (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .run_len (run_len),
    .bus     (i_bus),
    .state   (seq_state)
  );

  mem_execute i_execute (
    .clk (clk),
    .rst (rst),
    .bus (i_bus)
  );

  result_monitor i_result (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .state        (seq_state),
    .bus          (i_bus),
    .busy         (busy),
    .done         (done),
    .access_count (access_count),
    .error_count  (error_count),
    .cycle_count  (cycle_count),
    .signature    (signature),
    .ssl          (ssl)
  );

endmodule

`default_nettype wire

// File: verif/memspeed_tb.sv
// testbench for the memory speedometer.
// runs the cases from the input file and checks counts, signature and cycle bounds.

`default_nettype none

`include "memspeed_macros.svh"

module memspeed_tb;

  localparam int MAX_TESTS  = 32;
  localparam int WR_LAT     = `MEMSPEED_WR_LAT;
  localparam int RD_LAT     = `MEMSPEED_RD_LAT;
  localparam int REF_PERIOD = `MEMSPEED_REF_PERIOD;
  localparam int REF_CYCLES = `MEMSPEED_REF_CYCLES;

  // seven-segment dash and d, bit order gfedcba.
  localparam logic [6:0] SSL_IDLE = 7'b1000000;
  localparam logic [6:0] SSL_DONE = 7'b1011110;

  logic                         clk;
  logic                         rst;
  logic                         start;
  logic [`MEMSPEED_COUNT_W-1:0] run_len;
  logic                         busy;
  logic                         done;
  logic [`MEMSPEED_COUNT_W-1:0] access_count;
  logic [`MEMSPEED_COUNT_W-1:0] error_count;
  logic [31:0]                  cycle_count;
  logic [`MEMSPEED_DATA_W-1:0]  signature;
  logic [6:0]                   ssl;

  // three words per case: run_len, abort cycle, expected signature.
  logic [31:0] test_mem [3*MAX_TESTS];

  int errors;
  int checks;
  int test_errors;
  bit timed_out;

  memspeed i_dut (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .run_len      (run_len),
    .busy         (busy),
    .done         (done),
    .access_count (access_count),
    .error_count  (error_count),
    .cycle_count  (cycle_count),
    .signature    (signature),
    .ssl          (ssl)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("ERROR at %0t: %s, got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
    end
  endtask

  // inputs change one time unit after the rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // reads xor the group's write count, repeated in both halves.
  function automatic logic [31:0] pattern_signature(input int n);
    logic [31:0] sig;
    logic [15:0] wr;
    int          k;
    sig = '0;
    for (k = 0; k < n; k++) begin
      if (k % 4 != 0) begin
        wr  = 16'(k - k % 4);
        sig = sig ^ {wr, wr};
      end
    end
    return sig;
  endfunction

  task automatic check_reset_values();
    check_value(busy, 0, "busy not low after reset");
    check_value(done, 0, "done not low after reset");
    check_value(access_count, 0, "access_count not cleared by reset");
    check_value(error_count, 0, "error_count not cleared by reset");
    check_value(cycle_count, 0, "cycle_count not cleared by reset");
    check_value(signature, 0, "signature not cleared by reset");
    check_value(ssl, SSL_IDLE, "display not showing idle after reset");
  endtask

  task automatic wait_for_done(input int limit, output bit ok, output int cycles);
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < limit) begin
      next_cycle();
      cycles++;
      ok = done;
    end
  endtask

  task automatic pulse_start(input int n);
    run_len = 16'(n);
    start   = 1'b1;
    next_cycle();
    start   = 1'b0;
  endtask

  task automatic abort_run(input int n, input int abort_at);
    pulse_start(n);
    repeat (abort_at) next_cycle();
    check_value(busy, 1, "busy not high before the abort");
    rst = 1'b1;
    repeat (4) next_cycle();
    rst = 1'b0;
    check_reset_values();
  endtask

  task automatic run_and_check(input int n, input logic [31:0] file_sig);
    logic [31:0] model_sig;
    int          writes;
    int          reads;
    int          lower;
    int          upper;
    int          limit;
    int          elapsed;
    bit          ok;
    model_sig = pattern_signature(n);
    writes    = (n + 3) / 4;
    reads     = n - writes;
    // each access costs its latency, the acceptance cycle and one advance cycle.
    lower     = writes * WR_LAT + reads * RD_LAT + 2 * n + 1;
    limit     = 16 * n + 256;
    check_value(file_sig, model_sig, "input file signature disagrees with the pattern");
    pulse_start(n);
    check_value(busy, 1, "busy not high after start");
    check_value(done, 0, "done not cleared by start");
    wait_for_done(limit, ok, elapsed);
    if (!ok) begin
      timed_out = 1'b1;
      $display("timeout: done did not rise within %0d cycles for run_len %0d", limit, n);
    end else begin
      // at most one refresh window per started refresh period.
      upper = lower + REF_CYCLES * (elapsed / REF_PERIOD + 1);
      check_value(busy, 0, "busy still high at done");
      check_value(ssl, SSL_DONE, "display not showing done");
      check_value(access_count, n, "access_count differs from run_len");
      check_value(error_count, 0, "read mismatches counted");
      check_value(signature, model_sig, "signature differs from the pattern");
      check_value(cycle_count, elapsed, "cycle_count differs from the busy cycles seen");
      check_value(cycle_count >= lower, 1, "cycle_count below the latency sum");
      check_value(cycle_count <= upper, 1, "cycle_count above the refresh bound");
    end
  endtask

  initial begin
    int          num_tests;
    int          t;
    int          n;
    int          abort_at;
    int          gap;
    logic [31:0] exp_sig;
    rst         = 1'b1;
    start       = 1'b0;
    run_len     = '0;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    timed_out   = 1'b0;
    void'($urandom(32'ha440));
    $readmemh("verif/memspeed_input.txt", test_mem);
    repeat (4) next_cycle();
    rst = 1'b0;
    check_reset_values();
    repeat (3) next_cycle();
    check_reset_values();
    $display("test 0 idle after reset: %0d mismatches", test_errors);
    num_tests = 0;
    while (num_tests < MAX_TESTS && !$isunknown(test_mem[3*num_tests])) begin
      num_tests++;
    end
    if (num_tests == 0) begin
      errors++;
      $display("no test cases could be read from the input file");
    end
    t = 0;
    while (t < num_tests && !timed_out) begin
      n           = test_mem[3*t];
      abort_at    = test_mem[3*t+1];
      exp_sig     = test_mem[3*t+2];
      test_errors = 0;
      // odd cases start in the cycle right after the previous done.
      gap = (t % 2 == 1) ? 0 : 1 + $urandom % 6;
      repeat (gap) next_cycle();
      if (abort_at != 0) begin
        abort_run(n, abort_at);
      end
      run_and_check(n, exp_sig);
      $display("test %0d run_len %0d abort %0d: %0d mismatches", t + 1, n, abort_at,
               test_errors);
      t++;
    end
    $display("%0d tests run, %0d checks, %0d errors", t, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/memspeed_input.txt
// memory speedometer test cases, one per line, all hex.
// columns: run_len, abort cycle after start (0 for none), expected signature.
0010 0000 00000000
000C 0000 000C000C
0006 0000 00040004
0000 0000 00000000
0001 0000 00000000
000A 0000 000C000C
0028 001E 00040004
000D 0000 000C000C
000E 0000 00000000
0064 0000 00600060
00C8 0032 00040004
0022 0000 00200020
0102 0000 01000100
0405 0000 04000400

// File: vlog.f
+incdir+hw
hw/memspeed_pkg.sv
hw/mem_bus_if.sv
hw/seq_decode.sv
hw/mem_execute.sv
hw/result_monitor.sv
hw/memspeed.sv
verif/memspeed_tb.sv

// File: Bender.yml
package:
  name: memspeed

export_include_dirs:
  - hw

sources:
  - files:
      - hw/memspeed_pkg.sv
      - hw/mem_bus_if.sv
      - hw/seq_decode.sv
      - hw/mem_execute.sv
      - hw/result_monitor.sv
      - hw/memspeed.sv
  - target: test
    files:
      - verif/memspeed_tb.sv
